// File: Makefile
# Verilator simulation of the triangle setup front end
TOP       ?= TrianglePrepTb
FILELIST  ?= list.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/TrianglePrepTb.sv
`timescale 1ns/1ps
// Triangle setup front end testbench
// Directed tests stream whole triangles and compare every span pixel
// with a shift-based model of the float to fixed rule
module TrianglePrepTb;
    import RasterPkg::*;
    `include "TriangleStreamDefs.svh"

    localparam int SPAN_LENGTH     = 8;
    localparam int TOTAL_TRIANGLES = 15;
    localparam int WATCHDOG_CYCLES = TOTAL_TRIANGLES * (49 + SPAN_LENGTH + 10) + 200;
    localparam int SPAN_WAIT_LIMIT = SPAN_LENGTH + 20;
    // Last word is seen at the negedge before its sampling edge, hence 5 + 1
    localparam int FIRST_PIXEL_GAP = 6;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                    aclk;
    logic                    rstN;
    logic                    streamValid;
    logic                    streamLast;
    logic [STREAM_WIDTH-1:0] streamData;
    logic                    pixelValid;
    logic                    pixelLast;
    pixelColorT              pixelColor;

    logic [31:0] triWords [TRIANGLE_STREAM_SIZE];
    logic [31:0] lfsrState = 32'h4494;
    pixelColorT  expPixels [$];
    int          firstPixelCycle [$];
    int          cycleCount = 0;
    int          spanPos = 0;
    int          prevPixelCycle = 0;

    TrianglePrepTop #(
        .SPAN_LENGTH(SPAN_LENGTH)
    ) uut (
        .aclk(aclk),
        .rstN(rstN),
        .streamValid(streamValid),
        .streamLast(streamLast),
        .streamData(streamData),
        .pixelValid(pixelValid),
        .pixelLast(pixelLast),
        .pixelColor(pixelColor)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] makeFloat(input logic sign, input logic [7:0] expo,
                                              input logic [22:0] mant);
        return {sign, expo, mant};
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit)
                lfsrState = lfsrState ^ LFSR_TAPS;
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    // Float times 2^24, truncated toward zero, clamped to the signed 32-bit range
    function automatic logic [31:0] colorFixed(input logic [31:0] f);
        int     expo;
        int     sh;
        longint mant;
        longint mag;
        expo = int'(f[30:23]);
        mant = longint'({1'b1, f[22:0]});
        sh   = expo - 127 - 23 + 24;
        if (expo == 0)
            mag = 0;
        else if (expo == 255 || sh > 32)
            mag = 64'sd2147483648;
        else if (sh >= 0)
            mag = mant << sh;
        else if (sh > -32)
            mag = mant >> (-sh);
        else
            mag = 0;
        if (mag > 64'sd2147483647)
            return f[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
        return f[31] ? 32'(-mag) : 32'(mag);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic failRun(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    // Pixel monitor, samples at the falling edge where outputs are settled
    task automatic checkPixel();
        pixelColorT exp;
        if (expPixels.size() == 0)
            failRun("Pixel seen while no triangle was pending");
        exp = expPixels.pop_front();
        if (spanPos == 0)
            checkValue("first pixel cycle", firstPixelCycle.pop_front(), cycleCount);
        else
            checkValue("pixel spacing cycle", prevPixelCycle + 1, cycleCount);
        checkValue("pixelColor.r", exp.r, pixelColor.r);
        checkValue("pixelColor.g", exp.g, pixelColor.g);
        checkValue("pixelColor.b", exp.b, pixelColor.b);
        checkValue("pixelColor.a", exp.a, pixelColor.a);
        checkValue("pixelLast", 32'(spanPos == SPAN_LENGTH - 1), 32'(pixelLast));
        prevPixelCycle = cycleCount;
        spanPos = (spanPos == SPAN_LENGTH - 1) ? 0 : spanPos + 1;
    endtask

    always @(negedge aclk)
    begin
        if (rstN && streamValid && streamLast)
            firstPixelCycle.push_back(cycleCount + FIRST_PIXEL_GAP);
        if (rstN && pixelValid)
            checkPixel();
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        failRun("Watchdog expired before the tests completed");
    end

    // Queues the reference span, then streams all words of triWords
    task automatic sendTriangle();
        logic [31:0] st [4];
        logic [31:0] inc [4];
        pixelColorT  px;
        for (int c = 0; c < 4; c++)
        begin
            st[c]  = colorFixed(triWords[TRIANGLE_STREAM_INC_COLOR_R + c]);
            inc[c] = colorFixed(triWords[TRIANGLE_STREAM_INC_COLOR_R_X + c]);
        end
        for (int k = 0; k < SPAN_LENGTH; k++)
        begin
            px.r = st[0] + 32'(k) * inc[0];
            px.g = st[1] + 32'(k) * inc[1];
            px.b = st[2] + 32'(k) * inc[2];
            px.a = st[3] + 32'(k) * inc[3];
            expPixels.push_back(px);
        end
        for (int i = 0; i < TRIANGLE_STREAM_SIZE; i++)
        begin
            @(posedge aclk);
            streamValid <= 1'b1;
            streamLast  <= (i == TRIANGLE_STREAM_SIZE - 1);
            streamData  <= triWords[i];
        end
    endtask

    task automatic endStreamAndWait();
        int waited;
        waited = 0;
        @(posedge aclk);
        streamValid <= 1'b0;
        streamLast  <= 1'b0;
        while (expPixels.size() != 0)
        begin
            @(posedge aclk);
            waited++;
            if (waited > SPAN_WAIT_LIMIT)
                failRun("Span did not complete in time");
        end
    endtask

    task automatic fillRandomWords();
        for (int i = 0; i < TRIANGLE_STREAM_SIZE; i++)
            triWords[i] = randBits(32);
    endtask

    function automatic logic [31:0] randomColorFloat();
        return makeFloat(1'(randBits(1)), 8'(100 + randBits(5)), 23'(randBits(23)));
    endfunction

    task automatic setColorWords(input logic [31:0] r, input logic [31:0] g,
                                 input logic [31:0] b, input logic [31:0] a,
                                 input logic [31:0] rx, input logic [31:0] gx,
                                 input logic [31:0] bx, input logic [31:0] ax);
        triWords[TRIANGLE_STREAM_INC_COLOR_R]   = r;
        triWords[TRIANGLE_STREAM_INC_COLOR_G]   = g;
        triWords[TRIANGLE_STREAM_INC_COLOR_B]   = b;
        triWords[TRIANGLE_STREAM_INC_COLOR_A]   = a;
        triWords[TRIANGLE_STREAM_INC_COLOR_R_X] = rx;
        triWords[TRIANGLE_STREAM_INC_COLOR_G_X] = gx;
        triWords[TRIANGLE_STREAM_INC_COLOR_B_X] = bx;
        triWords[TRIANGLE_STREAM_INC_COLOR_A_X] = ax;
    endtask

    task automatic testResetState();
        repeat (20)
        begin
            @(negedge aclk);
            checkValue("pixelValid", 32'h0, 32'(pixelValid));
            checkValue("pixelLast", 32'h0, 32'(pixelLast));
        end
    endtask

    task automatic testExactColor();
        fillRandomWords();
        // 0.5, 0.25, 1.0, 0.0 with steps of 2^-8, 2^-10, 2^-6, 2^-12
        setColorWords(makeFloat(0, 126, 0), makeFloat(0, 125, 0), makeFloat(0, 127, 0),
                      makeFloat(0, 0, 0), makeFloat(0, 119, 0), makeFloat(0, 117, 0),
                      makeFloat(0, 121, 0), makeFloat(0, 115, 0));
        sendTriangle();
        endStreamAndWait();
    endtask

    task automatic testBypassRouting();
        for (int t = 0; t < 2; t++)
        begin
            fillRandomWords();
            for (int i = TRIANGLE_STREAM_INC_COLOR_R_Y; i <= TRIANGLE_STREAM_INC_TEX1_Q_Y; i++)
                triWords[i] = makeFloat(1'(randBits(1)), 8'hFE, 23'(randBits(23)));
            setColorWords(randomColorFloat(), randomColorFloat(), randomColorFloat(),
                          randomColorFloat(), randomColorFloat(), randomColorFloat(),
                          randomColorFloat(), randomColorFloat());
            sendTriangle();
        end
        endStreamAndWait();
    endtask

    task automatic testSignSaturation();
        fillRandomWords();
        // 300.0 and minus infinity saturate, the rest truncate toward zero
        setColorWords(makeFloat(0, 125, 23'h19999A), makeFloat(1, 126, 23'h7FFFFF),
                      makeFloat(0, 0, 0), makeFloat(0, 0, 23'h7FFFFF),
                      makeFloat(1, 118, 23'h555555), makeFloat(0, 100, 23'h123456),
                      makeFloat(0, 135, 23'h160000), makeFloat(1, 8'hFF, 0));
        sendTriangle();
        endStreamAndWait();
    endtask

    task automatic testBackToBack();
        for (int t = 0; t < 3; t++)
        begin
            fillRandomWords();
            setColorWords(makeFloat(0, 8'(120 + t), 0), makeFloat(1, 124, 0),
                          makeFloat(0, 126, 23'h400000), makeFloat(0, 127, 0),
                          makeFloat(1, 112, 0), makeFloat(0, 113, 0),
                          makeFloat(0, 8'(110 + t), 0), makeFloat(1, 111, 0));
            sendTriangle();
        end
        endStreamAndWait();
    endtask

    task automatic testRandomTriangles();
        for (int t = 0; t < 8; t++)
        begin
            fillRandomWords();
            for (int i = TRIANGLE_STREAM_INC_COLOR_R; i <= TRIANGLE_STREAM_INC_TEX1_Q_Y; i++)
                triWords[i] = randomColorFloat();
            sendTriangle();
        end
        endStreamAndWait();
    endtask

    initial
    begin
        rstN        = 1'b0;
        streamValid = 1'b0;
        streamLast  = 1'b0;
        streamData  = '0;
        repeat (4) @(posedge aclk);
        rstN <= 1'b1;
        testResetState();
        testExactColor();
        testBypassRouting();
        testSignSaturation();
        testBackToBack();
        testRandomTriangles();
        repeat (4) @(posedge aclk);
        if (expPixels.size() != 0 || firstPixelCycle.size() != 0)
        begin
            $display("Pixels were still pending at the end of the run");
            $display("TESTS FAILED");
            $fatal(1, "Pending pixels");
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: include/TriangleStreamDefs.svh
// Triangle stream word positions
// Included inside a module body, one name per word of the 49-word triangle

// Header and bounding box
localparam int TRIANGLE_STREAM_RESERVED      = 0;
localparam int TRIANGLE_STREAM_BB_START      = 1;
localparam int TRIANGLE_STREAM_BB_END        = 2;

// Edge functions
localparam int TRIANGLE_STREAM_INC_W0        = 3;
localparam int TRIANGLE_STREAM_INC_W1        = 4;
localparam int TRIANGLE_STREAM_INC_W2        = 5;
localparam int TRIANGLE_STREAM_INC_W0_X      = 6;
localparam int TRIANGLE_STREAM_INC_W1_X      = 7;
localparam int TRIANGLE_STREAM_INC_W2_X      = 8;
localparam int TRIANGLE_STREAM_INC_W0_Y      = 9;
localparam int TRIANGLE_STREAM_INC_W1_Y      = 10;
localparam int TRIANGLE_STREAM_INC_W2_Y      = 11;

// Colour starts, then x and y increments
localparam int TRIANGLE_STREAM_INC_COLOR_R   = 12;
localparam int TRIANGLE_STREAM_INC_COLOR_G   = 13;
localparam int TRIANGLE_STREAM_INC_COLOR_B   = 14;
localparam int TRIANGLE_STREAM_INC_COLOR_A   = 15;
localparam int TRIANGLE_STREAM_INC_COLOR_R_X = 16;
localparam int TRIANGLE_STREAM_INC_COLOR_G_X = 17;
localparam int TRIANGLE_STREAM_INC_COLOR_B_X = 18;
localparam int TRIANGLE_STREAM_INC_COLOR_A_X = 19;
localparam int TRIANGLE_STREAM_INC_COLOR_R_Y = 20;
localparam int TRIANGLE_STREAM_INC_COLOR_G_Y = 21;
localparam int TRIANGLE_STREAM_INC_COLOR_B_Y = 22;
localparam int TRIANGLE_STREAM_INC_COLOR_A_Y = 23;

// Depth
localparam int TRIANGLE_STREAM_INC_DEPTH_W   = 24;
localparam int TRIANGLE_STREAM_INC_DEPTH_W_X = 25;
localparam int TRIANGLE_STREAM_INC_DEPTH_W_Y = 26;
localparam int TRIANGLE_STREAM_INC_DEPTH_Z   = 27;
localparam int TRIANGLE_STREAM_INC_DEPTH_Z_X = 28;
localparam int TRIANGLE_STREAM_INC_DEPTH_Z_Y = 29;

// Texture units 0 and 1
localparam int TRIANGLE_STREAM_INC_TEX0_S    = 30;
localparam int TRIANGLE_STREAM_INC_TEX0_T    = 31;
localparam int TRIANGLE_STREAM_INC_TEX0_Q    = 32;
localparam int TRIANGLE_STREAM_INC_TEX0_S_X  = 33;
localparam int TRIANGLE_STREAM_INC_TEX0_T_X  = 34;
localparam int TRIANGLE_STREAM_INC_TEX0_Q_X  = 35;
localparam int TRIANGLE_STREAM_INC_TEX0_S_Y  = 36;
localparam int TRIANGLE_STREAM_INC_TEX0_T_Y  = 37;
localparam int TRIANGLE_STREAM_INC_TEX0_Q_Y  = 38;
localparam int TRIANGLE_STREAM_INC_TEX1_S    = 39;
localparam int TRIANGLE_STREAM_INC_TEX1_T    = 40;
localparam int TRIANGLE_STREAM_INC_TEX1_Q    = 41;
localparam int TRIANGLE_STREAM_INC_TEX1_S_X  = 42;
localparam int TRIANGLE_STREAM_INC_TEX1_T_X  = 43;
localparam int TRIANGLE_STREAM_INC_TEX1_Q_X  = 44;
localparam int TRIANGLE_STREAM_INC_TEX1_S_Y  = 45;
localparam int TRIANGLE_STREAM_INC_TEX1_T_Y  = 46;
localparam int TRIANGLE_STREAM_INC_TEX1_Q_Y  = 47;
localparam int TRIANGLE_STREAM_PADDING_1     = 48;

// File: list.f
+incdir+include
rtl/RasterPkg.sv
rtl/ValueDelay.sv
rtl/FloatToFixed.sv
rtl/TriangleStreamF2XConverter.sv
rtl/TriangleParamBuffer.sv
rtl/SpanColorInterpolator.sv
rtl/TrianglePrepTop.sv
dv/TrianglePrepTb.sv

// File: rtl/FloatToFixed.sv
`timescale 1ns/1ps
// Float to fixed converter
// Turns an IEEE single into a signed 32-bit fixed value scaled by
// 2^(-offset), truncating toward zero and saturating on overflow
// Two register stages
module FloatToFixed (
    input  logic                               aclk,
    input  logic                               rstN,
    input  RasterPkg::shiftT                   offset,
    input  logic [RasterPkg::STREAM_WIDTH-1:0] floatIn,
    output logic [RasterPkg::STREAM_WIDTH-1:0] fixedOut
);
    import RasterPkg::*;

    typedef struct packed {
        logic sign;
        logic saturate;
    } flagsT;

    logic [7:0]              expField;
    logic [23:0]             mantissa;
    logic signed [9:0]       shiftAmount;
    logic [STREAM_WIDTH-1:0] magnitude;
    logic [STREAM_WIDTH-1:0] magnitudeReg;
    flagsT                   flags;
    flagsT                   flagsReg;

    assign expField = floatIn[30:23];
    assign mantissa = {1'b1, floatIn[22:0]};

    // Weight of the mantissa LSB after scaling, 150 = bias + 23 fraction bits
    assign shiftAmount = $signed({2'b00, expField}) - $signed(10'd150) - 10'(offset);

    always_comb
    begin
        flags.sign     = floatIn[31];
        flags.saturate = 1'b0;
        magnitude      = '0;
        if (expField == 8'd0)
        begin
            // Zero and denormals
            magnitude = '0;
        end
        else if (expField == 8'hFF || shiftAmount >= 10'sd8)
        begin
            // Hidden bit would land on bit 31 or above
            flags.saturate = 1'b1;
        end
        else if (shiftAmount >= 10'sd0)
        begin
            magnitude = {8'b0, mantissa} << shiftAmount[2:0];
        end
        else
        begin
            magnitude = {8'b0, mantissa} >> 10'(-shiftAmount);
        end
    end

    // Stage one
    always_ff @(posedge aclk)
    begin
        magnitudeReg <= magnitude;
    end

    ValueDelay #(
        .payloadType(flagsT),
        .DELAY(1)
    ) flagDelay (
        .aclk(aclk),
        .rstN(rstN),
        .in(flags),
        .out(flagsReg)
    );

    // Stage two applies sign and clamps to the signed limits
    always_ff @(posedge aclk)
    begin
        if (flagsReg.saturate)
        begin
            fixedOut <= flagsReg.sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
        end
        else
        begin
            fixedOut <= flagsReg.sign ? -magnitudeReg : magnitudeReg;
        end
    end

endmodule

// File: rtl/RasterPkg.sv
// Raster package
// Stream geometry, fixed-point scale offsets and the structs shared by
// the triangle setup front end
package RasterPkg;

    localparam int STREAM_WIDTH         = 32;
    localparam int TRIANGLE_STREAM_SIZE = 49;
    localparam int INDEX_WIDTH          = 6;

    // Colour channel order inside the parameter and pixel arrays
    localparam int NUM_CHANNELS = 4;
    localparam int CH_R         = 0;
    localparam int CH_G         = 1;
    localparam int CH_B         = 2;
    localparam int CH_A         = 3;

    typedef logic signed [7:0] shiftT;

    // Binary point per parameter class, applied as value * 2^(-shift)
    localparam shiftT COLOR_SHIFT   = -8'sd24;
    localparam shiftT DEPTH_SHIFT   = -8'sd30;
    localparam shiftT TEXTURE_SHIFT = -8'sd28;
    localparam shiftT NULL_SHIFT    = 8'sd0;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [INDEX_WIDTH-1:0]  index;
        logic [STREAM_WIDTH-1:0] data;
    } streamWordT;

    typedef struct packed {
        logic [NUM_CHANNELS-1:0][STREAM_WIDTH-1:0] start;
        logic [NUM_CHANNELS-1:0][STREAM_WIDTH-1:0] incX;
    } colorParamsT;

    typedef struct packed {
        logic [STREAM_WIDTH-1:0] r;
        logic [STREAM_WIDTH-1:0] g;
        logic [STREAM_WIDTH-1:0] b;
        logic [STREAM_WIDTH-1:0] a;
    } pixelColorT;

endpackage

// File: rtl/SpanColorInterpolator.sv
`timescale 1ns/1ps
// Span colour interpolator
// Walks one span of SPAN_LENGTH pixels, stepping RGBA by the x increments
// and emitting one fixed-point colour per cycle
module SpanColorInterpolator #(
    parameter int SPAN_LENGTH = 8
) (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   paramsValid,
    input  RasterPkg::colorParamsT colorParams,
    output logic                   pixelValid,
    output logic                   pixelLast,
    output RasterPkg::pixelColorT  pixelColor
);
    import RasterPkg::*;

    localparam int COUNT_WIDTH = (SPAN_LENGTH > 1) ? $clog2(SPAN_LENGTH) : 1;

    logic [COUNT_WIDTH-1:0]                    pixelIndex;
    logic [NUM_CHANNELS-1:0][STREAM_WIDTH-1:0] channelAcc;
    logic [NUM_CHANNELS-1:0][STREAM_WIDTH-1:0] channelInc;

    // A new parameter set restarts the span at pixel 0
    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            pixelValid <= 1'b0;
            pixelLast  <= 1'b0;
            pixelIndex <= '0;
        end
        else if (paramsValid)
        begin
            pixelValid <= 1'b1;
            pixelLast  <= (SPAN_LENGTH == 1);
            pixelIndex <= '0;
        end
        else if (pixelValid)
        begin
            if (pixelLast)
            begin
                pixelValid <= 1'b0;
                pixelLast  <= 1'b0;
            end
            else
            begin
                pixelIndex <= pixelIndex + 1'b1;
                pixelLast  <= (int'(pixelIndex) == SPAN_LENGTH - 2);
            end
        end
    end

    // Channel accumulators wrap modulo 2^32
    always_ff @(posedge aclk)
    begin
        if (paramsValid)
        begin
            channelAcc <= colorParams.start;
            channelInc <= colorParams.incX;
        end
        else if (pixelValid && !pixelLast)
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                channelAcc[c] <= channelAcc[c] + channelInc[c];
            end
        end
    end

    assign pixelColor.r = channelAcc[CH_R];
    assign pixelColor.g = channelAcc[CH_G];
    assign pixelColor.b = channelAcc[CH_B];
    assign pixelColor.a = channelAcc[CH_A];

    // Last flag is computed a cycle ahead of the count it must line up with
    lastWithValid: assert property (@(posedge aclk) disable iff (!rstN)
        pixelLast |-> pixelValid && int'(pixelIndex) == SPAN_LENGTH - 1);

endmodule

// File: rtl/TriangleParamBuffer.sv
`timescale 1ns/1ps
// Triangle parameter buffer
// Collects the colour starts and x increments of the converted triangle
// and hands the full set to the span stage on the last word
module TriangleParamBuffer (
    input  logic                   aclk,
    input  logic                   rstN,
    input  RasterPkg::streamWordT  convWord,
    output RasterPkg::colorParamsT colorParams,
    output logic                   paramsValid
);
    import RasterPkg::*;
    `include "TriangleStreamDefs.svh"

    colorParamsT paramStore;

    // Store written by word position
    always_ff @(posedge aclk)
    begin
        if (convWord.valid)
        begin
            case (int'(convWord.index))
                TRIANGLE_STREAM_INC_COLOR_R:   paramStore.start[CH_R] <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_G:   paramStore.start[CH_G] <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_B:   paramStore.start[CH_B] <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_A:   paramStore.start[CH_A] <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_R_X: paramStore.incX[CH_R]  <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_G_X: paramStore.incX[CH_G]  <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_B_X: paramStore.incX[CH_B]  <= convWord.data;
                TRIANGLE_STREAM_INC_COLOR_A_X: paramStore.incX[CH_A]  <= convWord.data;
                default: ;
            endcase
        end
        // Last word is padding, so the store is complete here
        if (convWord.valid && convWord.last)
        begin
            colorParams <= paramStore;
        end
    end

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            paramsValid <= 1'b0;
        end
        else
        begin
            paramsValid <= convWord.valid && convWord.last;
        end
    end

    // Converter index and upstream framing must agree
    lastAtEnd: assert property (@(posedge aclk) disable iff (!rstN)
        (convWord.valid && convWord.last) |-> int'(convWord.index) == TRIANGLE_STREAM_SIZE - 1);

endmodule

// File: rtl/TrianglePrepTop.sv
`timescale 1ns/1ps
// Triangle setup front end
// Converter, parameter buffer and span interpolator in a straight chain
module TrianglePrepTop #(
    parameter int SPAN_LENGTH = 8
) (
    input  logic                               aclk,
    input  logic                               rstN,
    input  logic                               streamValid,
    input  logic                               streamLast,
    input  logic [RasterPkg::STREAM_WIDTH-1:0] streamData,
    output logic                               pixelValid,
    output logic                               pixelLast,
    output RasterPkg::pixelColorT              pixelColor
);
    import RasterPkg::*;

    streamWordT  convWord;
    colorParamsT colorParams;
    logic        paramsValid;

    TriangleStreamF2XConverter converter (
        .aclk(aclk),
        .rstN(rstN),
        .streamValid(streamValid),
        .streamLast(streamLast),
        .streamData(streamData),
        .convWord(convWord)
    );

    TriangleParamBuffer paramBuffer (
        .aclk(aclk),
        .rstN(rstN),
        .convWord(convWord),
        .colorParams(colorParams),
        .paramsValid(paramsValid)
    );

    SpanColorInterpolator #(
        .SPAN_LENGTH(SPAN_LENGTH)
    ) interpolator (
        .aclk(aclk),
        .rstN(rstN),
        .paramsValid(paramsValid),
        .colorParams(colorParams),
        .pixelValid(pixelValid),
        .pixelLast(pixelLast),
        .pixelColor(pixelColor)
    );

endmodule

// File: rtl/TriangleStreamF2XConverter.sv
`timescale 1ns/1ps
// Triangle stream converter
// Tracks the word position in the triangle stream, converts colour, depth
// and texture words to fixed point and passes all other words unchanged
// Fully pipelined, a word shows up on convWord three edges after sampling
module TriangleStreamF2XConverter (
    input  logic                               aclk,
    input  logic                               rstN,
    input  logic                               streamValid,
    input  logic                               streamLast,
    input  logic [RasterPkg::STREAM_WIDTH-1:0] streamData,
    output RasterPkg::streamWordT              convWord
);
    import RasterPkg::*;
    `include "TriangleStreamDefs.svh"

    typedef struct packed {
        logic  convert;
        shiftT shift;
    } lutEntryT;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [INDEX_WIDTH-1:0]  index;
        logic [STREAM_WIDTH-1:0] data;
        logic                    convert;
    } delayWordT;

    function automatic lutEntryT buildEntry(input int idx);
        lutEntryT entry;
        entry.convert = 1'b1;
        entry.shift   = NULL_SHIFT;
        if (idx inside {[TRIANGLE_STREAM_INC_COLOR_R : TRIANGLE_STREAM_INC_COLOR_A_Y]})
            entry.shift = COLOR_SHIFT;
        else if (idx inside {[TRIANGLE_STREAM_INC_DEPTH_W : TRIANGLE_STREAM_INC_DEPTH_Z_Y]})
            entry.shift = DEPTH_SHIFT;
        else if (idx inside {[TRIANGLE_STREAM_INC_TEX0_S : TRIANGLE_STREAM_INC_TEX1_Q_Y]})
            entry.shift = TEXTURE_SHIFT;
        else
            entry.convert = 1'b0;
        return entry;
    endfunction

    logic [INDEX_WIDTH-1:0]  wordIndex;
    lutEntryT                convertLut [TRIANGLE_STREAM_SIZE];
    lutEntryT                currentEntry;
    logic [STREAM_WIDTH-1:0] floatReg;
    shiftT                   offsetReg;
    logic [STREAM_WIDTH-1:0] fixedData;
    delayWordT               delayIn;
    delayWordT               delayOut;

    // Convert-or-bypass table, one entry per word position
    for (genvar i = 0; i < TRIANGLE_STREAM_SIZE; i++)
    begin : gLut
        assign convertLut[i] = buildEntry(i);
    end

    assign currentEntry = convertLut[wordIndex];

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            wordIndex <= '0;
        end
        else if (streamValid)
        begin
            wordIndex <= streamLast ? '0 : wordIndex + 1'b1;
        end
    end

    // Lookup stage feeding the converter
    always_ff @(posedge aclk)
    begin
        floatReg  <= streamData;
        offsetReg <= currentEntry.shift;
    end

    FloatToFixed convert (
        .aclk(aclk),
        .rstN(rstN),
        .offset(offsetReg),
        .floatIn(floatReg),
        .fixedOut(fixedData)
    );

    // Raw word and routing bit travel alongside the converter
    assign delayIn = '{
        valid:   streamValid,
        last:    streamLast,
        index:   wordIndex,
        data:    streamData,
        convert: currentEntry.convert
    };

    ValueDelay #(
        .payloadType(delayWordT),
        .DELAY(3)
    ) bypassDelay (
        .aclk(aclk),
        .rstN(rstN),
        .in(delayIn),
        .out(delayOut)
    );

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            convWord <= '0;
        end
        else
        begin
            convWord.valid <= delayOut.valid;
            convWord.last  <= delayOut.last;
            convWord.index <= delayOut.index;
            convWord.data  <= delayOut.convert ? fixedData : delayOut.data;
        end
    end

    // A triangle must end with last before the index runs past the table
    indexInRange: assert property (@(posedge aclk) disable iff (!rstN)
        int'(wordIndex) < TRIANGLE_STREAM_SIZE);

endmodule

// File: rtl/ValueDelay.sv
`timescale 1ns/1ps
// Value delay line
// Shifts any packed payload through DELAY register stages
module ValueDelay #(
    parameter type payloadType = logic,
    parameter int  DELAY       = 1
) (
    input  logic       aclk,
    input  logic       rstN,
    input  payloadType in,
    output payloadType out
);

    payloadType stages [DELAY];

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            // All-zero payload keeps any valid field inactive
            for (int i = 0; i < DELAY; i++)
            begin
                stages[i] <= '0;
            end
        end
        else
        begin
            stages[0] <= in;
            for (int i = 1; i < DELAY; i++)
            begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[DELAY-1];

    delayPositive: assert property (@(posedge aclk) DELAY >= 1);

endmodule
